// File: all.f
csr_pkg.sv
csr_access_if.sv
trap_if.sv
csr_op_unit.sv
csr_file.sv
trap_ctrl.sv
csr_top.sv
csr_tb.sv

// File: Makefile
# Verilator simulation of the CSR subsystem

TOP       ?= csr_tb
LOG       ?= sim.log
VERILATOR ?= verilator
BUILD_DIR ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --assert --timescale 1ns/1ps

.PHONY: sim clean

# Pass or fail is decided by the log contents
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: csr_tb.sv
`timescale 1ns/1ps

module csr_tb;
    import csr_pkg::*;

    localparam csr_word_t hart_id     = 32'h0000_0005;
    localparam csr_word_t trap_vector = 32'h0000_2000;
    localparam csr_word_t mepc_reset  = 32'h0000_8000;

    localparam int max_entries = 40;
    localparam int resp_limit  = 3;

    // Entry kinds
    localparam int k_csr  = 0;
    localparam int k_exc  = 1;
    localparam int k_mret = 2;
    localparam int k_both = 3;

    logic        clk;
    logic        rst;
    logic        csr_valid;
    csr_op_e     csr_op;
    logic [11:0] csr_addr;
    csr_word_t   csr_src;
    logic        csr_rd_valid;
    csr_word_t   csr_rd_value;
    logic        exc_valid;
    exc_cause_e  exc_cause;
    csr_word_t   exc_pc;
    csr_word_t   exc_tval;
    logic        mret_valid;
    logic        redirect_valid;
    csr_word_t   redirect_pc;

    // Data holds the CSR source or the trap PC
    int          tab_kind  [max_entries];
    csr_op_e     tab_op    [max_entries];
    logic [11:0] tab_addr  [max_entries];
    exc_cause_e  tab_cause [max_entries];
    csr_word_t   tab_data  [max_entries];
    csr_word_t   tab_tval  [max_entries];
    csr_word_t   tab_exp   [max_entries];
    string       tab_name  [max_entries];
    int          n_entries;
    logic        table_ready;

    int        errors;
    int        checks;
    csr_word_t r1;
    csr_word_t r2;
    csr_word_t r3;

    csr_top #(
        .HART_ID     (hart_id),
        .TRAP_VECTOR (trap_vector),
        .MEPC_RESET  (mepc_reset)
    ) csr_top_i (
        .clk            (clk),
        .rst            (rst),
        .csr_valid      (csr_valid),
        .csr_op         (csr_op),
        .csr_addr       (csr_addr),
        .csr_src        (csr_src),
        .csr_rd_valid   (csr_rd_valid),
        .csr_rd_value   (csr_rd_value),
        .exc_valid      (exc_valid),
        .exc_cause      (exc_cause),
        .exc_pc         (exc_pc),
        .exc_tval       (exc_tval),
        .mret_valid     (mret_valid),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    always #5 clk = ~clk;

    task automatic add_csr(input string name, input csr_op_e op, input logic [11:0] addr,
                           input csr_word_t src, input csr_word_t exp);
        tab_kind[n_entries]  = k_csr;
        tab_op[n_entries]    = op;
        tab_addr[n_entries]  = addr;
        tab_cause[n_entries] = not_exception;
        tab_data[n_entries]  = src;
        tab_tval[n_entries]  = '0;
        tab_exp[n_entries]   = exp;
        tab_name[n_entries]  = name;
        n_entries++;
    endtask

    task automatic add_trap(input string name, input int kind, input exc_cause_e cause,
                            input csr_word_t pc, input csr_word_t tval, input csr_word_t exp);
        tab_kind[n_entries]  = kind;
        tab_op[n_entries]    = csr_rw;
        tab_addr[n_entries]  = '0;
        tab_cause[n_entries] = cause;
        tab_data[n_entries]  = pc;
        tab_tval[n_entries]  = tval;
        tab_exp[n_entries]   = exp;
        tab_name[n_entries]  = name;
        n_entries++;
    endtask

    task automatic check_rd(input string name, input csr_word_t exp, input csr_word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_redirect(input string name, input csr_word_t exp,
                                  input csr_word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected redirect %h, actual %h", name, exp, act);
        end
    endtask

    task automatic apply_entry(input int idx);
        logic got;
        @(negedge clk);
        if (tab_kind[idx] == k_csr) begin
            csr_valid = 1'b1;
            csr_op    = tab_op[idx];
            csr_addr  = tab_addr[idx];
            csr_src   = tab_data[idx];
        end else begin
            exc_valid  = (tab_kind[idx] != k_mret);
            mret_valid = (tab_kind[idx] != k_exc);
            exc_cause  = tab_cause[idx];
            exc_pc     = tab_data[idx];
            exc_tval   = tab_tval[idx];
        end
        @(negedge clk);
        csr_valid  = 1'b0;
        exc_valid  = 1'b0;
        mret_valid = 1'b0;
        got = 1'b0;
        for (int w = 0; w < resp_limit && !got; w++) begin
            if (w > 0) begin
                @(negedge clk);
            end
            got = (tab_kind[idx] == k_csr) ? csr_rd_valid : redirect_valid;
        end
        if (!got) begin
            errors++;
            $display("No response pulse for %s within %0d cycles", tab_name[idx], resp_limit);
        end else if (tab_kind[idx] == k_csr) begin
            check_rd(tab_name[idx], tab_exp[idx], csr_rd_value);
        end else begin
            check_redirect(tab_name[idx], tab_exp[idx], redirect_pc);
            // A redirect is a single pulse
            @(negedge clk);
            if (redirect_valid) begin
                errors++;
                $display("Second redirect pulse after %s", tab_name[idx]);
            end
        end
    endtask

    initial begin
        wait (table_ready);
        repeat (n_entries * 5 + 100) @(posedge clk);
        $display("Watchdog expired before the table finished");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        csr_valid   = 1'b0;
        csr_op      = csr_rw;
        csr_addr    = '0;
        csr_src     = '0;
        exc_valid   = 1'b0;
        exc_cause   = not_exception;
        exc_pc      = '0;
        exc_tval    = '0;
        mret_valid  = 1'b0;
        errors      = 0;
        checks      = 0;
        n_entries   = 0;
        table_ready = 1'b0;

        void'($urandom(32'hccb2_d232));
        r1 = $urandom;
        r2 = $urandom;
        r3 = $urandom;

        // Reset values and read-only registers
        // CSRRS with a zero source reads without writing
        add_csr("mhartid", csr_rs, 12'hf14, '0, hart_id);
        add_csr("misa", csr_rs, 12'h301, '0, 32'h4000_0100);
        add_csr("mtvec", csr_rs, 12'h305, '0, trap_vector);
        add_csr("mepc reset", csr_rs, 12'h341, '0, mepc_reset);
        add_csr("unknown addr", csr_rs, 12'h7c0, '0, '0);
        add_csr("misa write", csr_rw, 12'h301, 32'hffff_ffff, 32'h4000_0100);
        add_csr("misa after write", csr_rs, 12'h301, '0, 32'h4000_0100);
        // Read-modify-write on mscratch
        add_csr("mscratch rw", csr_rw, 12'h340, r1, '0);
        add_csr("mscratch rs", csr_rs, 12'h340, r2, r1);
        add_csr("mscratch rc", csr_rc, 12'h340, r3, r1 | r2);
        add_csr("mscratch rs zero", csr_rs, 12'h340, '0, (r1 | r2) & ~r3);
        add_csr("mscratch read", csr_rs, 12'h340, '0, (r1 | r2) & ~r3);
        // Masks
        add_csr("mie write", csr_rw, 12'h304, 32'hffff_ffff, '0);
        add_csr("mie masked", csr_rs, 12'h304, '0, 32'h0000_0888);
        add_csr("mip write", csr_rw, 12'h344, 32'hffff_ffff, '0);
        add_csr("mip masked", csr_rs, 12'h344, '0, 32'h0000_0008);
        add_csr("mstatus set m", csr_rw, 12'h300, 32'h0000_1808, '0);
        add_csr("mstatus mpp 10", csr_rw, 12'h300, 32'h0000_1008, 32'h0000_1808);
        add_csr("mstatus mpp kept", csr_rs, 12'h300, '0, 32'h0000_1808);
        // Exception entry, mcause first holds a nonzero value
        add_csr("mcause preset", csr_rw, 12'h342, 32'd7, 32'd0);
        add_trap("misaligned", k_exc, i_addr_misaligned, 32'h400, 32'h402, trap_vector);
        add_csr("mepc trap", csr_rs, 12'h341, '0, 32'h0000_0400);
        add_csr("mcause misaligned", csr_rs, 12'h342, '0, 32'd0);
        add_csr("mtval trap", csr_rs, 12'h343, '0, 32'h0000_0402);
        add_csr("mstatus trap", csr_rs, 12'h300, '0, 32'h0000_1880);
        // MRET to user, then to supervisor, then ECALL from machine
        add_csr("mpp to user", csr_rw, 12'h300, 32'h0000_0080, 32'h0000_1880);
        add_trap("mret to user", k_mret, not_exception, '0, '0, 32'h0000_0400);
        add_trap("ecall user", k_exc, ecall, 32'h500, '0, trap_vector);
        add_csr("mcause ecall u", csr_rs, 12'h342, '0, 32'd8);
        add_csr("mpp to sup", csr_rw, 12'h300, 32'h0000_0880, 32'h0000_0080);
        add_trap("mret to sup", k_mret, not_exception, '0, '0, 32'h0000_0500);
        add_trap("ecall sup", k_exc, ecall, 32'h600, '0, trap_vector);
        add_csr("mcause ecall s", csr_rs, 12'h342, '0, 32'd9);
        add_trap("ecall machine", k_exc, ecall, 32'h700, '0, trap_vector);
        add_csr("mcause ecall m", csr_rs, 12'h342, '0, 32'd11);
        // Exception beats a simultaneous MRET
        add_trap("exc and mret", k_both, i_addr_misaligned, 32'h800, '0, trap_vector);
        add_csr("mepc priority", csr_rs, 12'h341, '0, 32'h0000_0800);
        table_ready = 1'b1;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < n_entries; i++) begin
            apply_entry(i);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: csr_top.sv
`timescale 1ns/1ps

module csr_top #(
    parameter csr_pkg::csr_word_t HART_ID     = 32'd0,
    parameter csr_pkg::csr_word_t TRAP_VECTOR = 32'h0000_1000,
    parameter csr_pkg::csr_word_t MEPC_RESET  = 32'h0001_0000
) (
    input  logic                 clk,
    input  logic                 rst,

    // CSR instruction port
    input  logic                 csr_valid,
    input  csr_pkg::csr_op_e     csr_op,
    input  logic [11:0]          csr_addr,
    input  csr_pkg::csr_word_t   csr_src,
    output logic                 csr_rd_valid,
    output csr_pkg::csr_word_t   csr_rd_value,

    // Exception and MRET requests
    input  logic                 exc_valid,
    input  csr_pkg::exc_cause_e  exc_cause,
    input  csr_pkg::csr_word_t   exc_pc,
    input  csr_pkg::csr_word_t   exc_tval,
    input  logic                 mret_valid,
    output logic                 redirect_valid,
    output csr_pkg::csr_word_t   redirect_pc
);

    csr_access_if acc_if ();
    trap_if       trp_if ();

    csr_op_unit csr_op_unit_i (
        .clk          (clk),
        .rst          (rst),
        .csr_valid    (csr_valid),
        .csr_op       (csr_op),
        .csr_addr     (csr_addr),
        .csr_src      (csr_src),
        .csr_rd_valid (csr_rd_valid),
        .csr_rd_value (csr_rd_value),
        .acc          (acc_if.op)
    );

    csr_file #(
        .HART_ID     (HART_ID),
        .TRAP_VECTOR (TRAP_VECTOR),
        .MEPC_RESET  (MEPC_RESET)
    ) csr_file_i (
        .clk (clk),
        .rst (rst),
        .acc (acc_if.file),
        .trp (trp_if.file)
    );

    trap_ctrl trap_ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .exc_valid      (exc_valid),
        .exc_cause      (exc_cause),
        .exc_pc         (exc_pc),
        .exc_tval       (exc_tval),
        .mret_valid     (mret_valid),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .trp            (trp_if.ctrl)
    );

endmodule

// File: trap_ctrl.sv
`timescale 1ns/1ps

module trap_ctrl (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 exc_valid,
    input  csr_pkg::exc_cause_e  exc_cause,
    input  csr_pkg::csr_word_t   exc_pc,
    input  csr_pkg::csr_word_t   exc_tval,
    input  logic                 mret_valid,

    output logic                 redirect_valid,
    output csr_pkg::csr_word_t   redirect_pc,

    trap_if.ctrl                 trp
);
    import csr_pkg::*;

    logic      take_exc;
    logic      take_mret;
    csr_word_t target_pc;

    // Exceptions win, an MRET in the same cycle is dropped
    assign take_exc  = exc_valid && (exc_cause != not_exception);
    assign take_mret = mret_valid && !take_exc;

    assign trp.trap_take  = take_exc;
    assign trp.trap_cause = exc_cause;
    assign trp.trap_pc    = exc_pc;
    assign trp.trap_tval  = exc_tval;
    assign trp.mret_take  = take_mret;

    // mepc sampled before the CSR file updates it
    assign target_pc = take_exc ? trp.mtvec : trp.mepc;

    always_ff @(posedge clk) begin
        if (rst) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= take_exc || take_mret;
        end
    end

    always_ff @(posedge clk) begin
        if (take_exc || take_mret) begin
            redirect_pc <= target_pc;
        end
    end

    // Covers both mtvec and mepc alignment in the CSR file
    a_redirect_aligned: assert property (
        @(posedge clk) disable iff (rst)
        redirect_valid |-> (redirect_pc[1:0] == 2'b00)
    );

endmodule

// File: csr_file.sv
`timescale 1ns/1ps

module csr_file #(
    parameter csr_pkg::csr_word_t HART_ID     = 32'd0,
    parameter csr_pkg::csr_word_t TRAP_VECTOR = 32'h0000_1000,
    parameter csr_pkg::csr_word_t MEPC_RESET  = 32'h0001_0000
) (
    input  logic        clk,
    input  logic        rst,

    csr_access_if.file  acc,
    trap_if.file        trp
);
    import csr_pkg::*;

    // mstatus is kept as its three implemented fields
    logic       st_mie;
    logic       st_mpie;
    priv_mode_e st_mpp;
    priv_mode_e priv_mode;

    csr_word_t  mie_r;
    csr_word_t  mip_r;
    csr_word_t  mscratch_r;
    csr_word_t  mepc_r;
    csr_word_t  mcause_r;
    csr_word_t  mtval_r;

    csr_word_t  mstatus_value;
    logic [1:0] wr_mpp;

    logic wr_mstatus;
    logic wr_mie;
    logic wr_mip;
    logic wr_mscratch;
    logic wr_mepc;
    logic wr_mcause;
    logic wr_mtval;

    function automatic csr_word_t cause_code(exc_cause_e cause, priv_mode_e mode);
        csr_word_t code;
        code = cause_misaligned_fetch;
        if (cause == ecall) begin
            case (mode)
                user:       code = cause_ecall_u;
                supervisor: code = cause_ecall_s;
                default:    code = cause_ecall_m;
            endcase
        end
        return code;
    endfunction

    assign wr_mstatus  = acc.wr_en && (acc.wr_addr == addr_mstatus);
    assign wr_mie      = acc.wr_en && (acc.wr_addr == addr_mie);
    assign wr_mip      = acc.wr_en && (acc.wr_addr == addr_mip);
    assign wr_mscratch = acc.wr_en && (acc.wr_addr == addr_mscratch);
    assign wr_mepc     = acc.wr_en && (acc.wr_addr == addr_mepc);
    assign wr_mcause   = acc.wr_en && (acc.wr_addr == addr_mcause);
    assign wr_mtval    = acc.wr_en && (acc.wr_addr == addr_mtval);

    assign wr_mpp = acc.wr_data[mstatus_mpp_hi:mstatus_mpp_lo];

    // Trap and MRET win over a software write to mstatus
    always_ff @(posedge clk) begin
        if (rst) begin
            st_mie    <= 1'b0;
            st_mpie   <= 1'b0;
            st_mpp    <= user;
            priv_mode <= machine;
        end else if (trp.trap_take) begin
            st_mpie   <= st_mie;
            st_mie    <= 1'b0;
            st_mpp    <= priv_mode;
            priv_mode <= machine;
        end else if (trp.mret_take) begin
            st_mie    <= st_mpie;
            st_mpie   <= 1'b1;
            priv_mode <= st_mpp;
            st_mpp    <= user;
        end else if (wr_mstatus) begin
            st_mie  <= acc.wr_data[mstatus_mie_bit];
            st_mpie <= acc.wr_data[mstatus_mpie_bit];
            // Reserved mode 2'b10 leaves mpp as it was
            if (wr_mpp != 2'b10) begin
                st_mpp <= priv_mode_e'(wr_mpp);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mie_r      <= '0;
            mip_r      <= '0;
            mscratch_r <= '0;
        end else begin
            if (wr_mie) begin
                mie_r <= acc.wr_data & mie_mask;
            end
            if (wr_mip) begin
                mip_r <= acc.wr_data & mip_mask;
            end
            if (wr_mscratch) begin
                mscratch_r <= acc.wr_data;
            end
        end
    end

    // Trap values take precedence over software writes
    always_ff @(posedge clk) begin
        if (rst) begin
            mepc_r   <= MEPC_RESET;
            mcause_r <= '0;
            mtval_r  <= '0;
        end else if (trp.trap_take) begin
            // Word-aligned, IALIGN is 32
            mepc_r   <= {trp.trap_pc[31:2], 2'b00};
            mcause_r <= cause_code(trp.trap_cause, priv_mode);
            mtval_r  <= trp.trap_tval;
        end else begin
            if (wr_mepc) begin
                mepc_r <= {acc.wr_data[31:2], 2'b00};
            end
            if (wr_mcause) begin
                mcause_r <= acc.wr_data;
            end
            if (wr_mtval) begin
                mtval_r <= acc.wr_data;
            end
        end
    end

    always_comb begin
        mstatus_value = '0;
        mstatus_value[mstatus_mie_bit]  = st_mie;
        mstatus_value[mstatus_mpie_bit] = st_mpie;
        mstatus_value[mstatus_mpp_hi:mstatus_mpp_lo] = st_mpp;
    end

    // Read port, unknown addresses return zero
    always_comb begin
        case (acc.rd_addr)
            addr_mvendorid:  acc.rd_data = '0;
            addr_marchid:    acc.rd_data = '0;
            addr_mimpid:     acc.rd_data = '0;
            addr_mhartid:    acc.rd_data = HART_ID;
            addr_mstatus:    acc.rd_data = mstatus_value;
            addr_misa:       acc.rd_data = misa_value;
            addr_mie:        acc.rd_data = mie_r;
            addr_mtvec:      acc.rd_data = TRAP_VECTOR;
            addr_mcounteren: acc.rd_data = '0;
            addr_mscratch:   acc.rd_data = mscratch_r;
            addr_mepc:       acc.rd_data = mepc_r;
            addr_mcause:     acc.rd_data = mcause_r;
            addr_mtval:      acc.rd_data = mtval_r;
            addr_mip:        acc.rd_data = mip_r;
            default:         acc.rd_data = '0;
        endcase
    end

    assign trp.mepc  = mepc_r;
    assign trp.mtvec = TRAP_VECTOR;

    a_priv_legal: assert property (
        @(posedge clk) disable iff (rst)
        priv_mode != 2'b10
    );

    // The trap controller arbitrates, so both commands never arrive together
    a_trap_mret_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(trp.trap_take && trp.mret_take)
    );

endmodule

// File: csr_op_unit.sv
`timescale 1ns/1ps

module csr_op_unit (
    input  logic                clk,
    input  logic                rst,

    input  logic                csr_valid,
    input  csr_pkg::csr_op_e    csr_op,
    input  logic [11:0]         csr_addr,
    input  csr_pkg::csr_word_t  csr_src,

    output logic                csr_rd_valid,
    output csr_pkg::csr_word_t  csr_rd_value,

    csr_access_if.op            acc
);
    import csr_pkg::*;

    csr_word_t old_value;
    csr_word_t new_value;
    logic      do_write;

    // Read and write target the same register in the same cycle
    assign acc.rd_addr = csr_addr;
    assign acc.wr_addr = csr_addr;
    assign old_value   = acc.rd_data;

    always_comb begin
        case (csr_op)
            csr_rw:  new_value = csr_src;
            csr_rs:  new_value = old_value | csr_src;
            csr_rc:  new_value = old_value & ~csr_src;
            default: new_value = old_value;
        endcase
    end

    // CSRRS/CSRRC with a zero source must not write
    assign do_write = csr_valid && ((csr_op == csr_rw) || (csr_src != '0));

    assign acc.wr_data = new_value;
    assign acc.wr_en   = do_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            csr_rd_valid <= 1'b0;
        end else begin
            csr_rd_valid <= csr_valid;
        end
    end

    // Value before the write, returned to rd
    always_ff @(posedge clk) begin
        if (csr_valid) begin
            csr_rd_value <= old_value;
        end
    end

    // Only the three register forms are decoded
    a_op_legal: assert property (
        @(posedge clk) disable iff (rst)
        csr_valid |-> (csr_op != 2'b00)
    );

endmodule

// File: trap_if.sv
`timescale 1ns/1ps

interface trap_if;
    import csr_pkg::*;

    // Exception entry, one-cycle pulse
    logic       trap_take;
    exc_cause_e trap_cause;
    csr_word_t  trap_pc;
    csr_word_t  trap_tval;

    // Return from machine mode, one-cycle pulse
    logic       mret_take;

    // Redirect targets held by the CSR file
    csr_word_t  mepc;
    csr_word_t  mtvec;

    modport ctrl (
        output trap_take, trap_cause, trap_pc, trap_tval, mret_take,
        input  mepc, mtvec
    );

    modport file (
        input  trap_take, trap_cause, trap_pc, trap_tval, mret_take,
        output mepc, mtvec
    );

endinterface

// File: csr_access_if.sv
`timescale 1ns/1ps

interface csr_access_if;
    import csr_pkg::*;

    // Read side, combinational
    logic [11:0] rd_addr;
    csr_word_t   rd_data;

    // Write side, committed on the clock edge
    logic [11:0] wr_addr;
    csr_word_t   wr_data;
    logic        wr_en;

    modport op (
        output rd_addr, wr_addr, wr_data, wr_en,
        input  rd_data
    );

    modport file (
        input  rd_addr, wr_addr, wr_data, wr_en,
        output rd_data
    );

endinterface

// File: csr_pkg.sv
package csr_pkg;

    typedef logic [31:0] csr_word_t;

    // Machine-mode CSR addresses decoded by the register file
    typedef enum logic [11:0] {
        addr_mvendorid  = 12'hf11,
        addr_marchid    = 12'hf12,
        addr_mimpid     = 12'hf13,
        addr_mhartid    = 12'hf14,
        addr_mstatus    = 12'h300,
        addr_misa       = 12'h301,
        addr_mie        = 12'h304,
        addr_mtvec      = 12'h305,
        addr_mcounteren = 12'h306,
        addr_mscratch   = 12'h340,
        addr_mepc       = 12'h341,
        addr_mcause     = 12'h342,
        addr_mtval      = 12'h343,
        addr_mip        = 12'h344
    } csr_addr_e;

    // Same encoding as funct3 of the register forms
    typedef enum logic [1:0] {
        csr_rw = 2'b01,
        csr_rs = 2'b10,
        csr_rc = 2'b11
    } csr_op_e;

    typedef enum logic [1:0] {
        not_exception     = 2'b00,
        i_addr_misaligned = 2'b01,
        ecall             = 2'b11
    } exc_cause_e;

    // 2'b10 is reserved
    typedef enum logic [1:0] {
        user       = 2'b00,
        supervisor = 2'b01,
        machine    = 2'b11
    } priv_mode_e;

    // mstatus field positions
    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;
    localparam int mstatus_mpp_lo   = 11;
    localparam int mstatus_mpp_hi   = 12;

    // Writable bits of mie and mip
    localparam csr_word_t mie_mask = 32'h0000_0888;
    localparam csr_word_t mip_mask = 32'h0000_0008;

    // RV32I, MXL = 1
    localparam csr_word_t misa_value = 32'h4000_0100;

    // mcause values, interrupt bit clear
    localparam csr_word_t cause_misaligned_fetch = 32'd0;
    localparam csr_word_t cause_ecall_u          = 32'd8;
    localparam csr_word_t cause_ecall_s          = 32'd9;
    localparam csr_word_t cause_ecall_m          = 32'd11;

endpackage
